// File: tb_credit_rx_input.txt
# Columns: stall withhold send data deq, all hex, one line per clock cycle
# Data FF takes the beat from the testbench LCG instead
0 0 0 00 0
0 0 0 00 0
0 0 1 11 0
0 0 1 22 0
0 0 1 FF 0
0 0 1 33 1
0 0 1 44 1
0 0 0 00 1
1 0 1 55 0
1 0 1 FF 1
1 0 0 00 1
1 0 0 00 0
0 3 1 66 0
0 3 1 77 1
0 3 0 00 1
0 3 0 00 0
0 3 1 FF 1
0 3 1 88 1
0 2 0 00 1
0 2 1 99 0
0 0 1 FF 1
0 0 1 AA 1
0 0 1 BB 1
0 0 0 00 1
0 8 1 CC 1
0 8 0 00 1
0 0 0 00 1
0 0 0 00 0

// File: src.f
credit_pkg.sv
credit_counter.sv
credit_receiver.sv
rx_buffer.sv
credit_rx_top.sv
credit_rx_assert.sv
tb_credit_rx.sv

// File: tb_credit_rx.sv
module tb_credit_rx;

  import credit_pkg::*;

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------

  logic    clk;
  logic    arst_n;
  logic    push_credit_stall;
  logic    push_credit;
  logic    push_valid;
  data_t   push_data;
  logic    deq;
  logic    deq_valid;
  data_t   deq_data;
  credit_t credit_withhold;
  credit_t credit_count;

  // One entry per stimulus line
  logic    st_stall [$];
  credit_t st_withhold [$];
  logic    st_send [$];
  data_t   st_data [$];
  logic    st_deq [$];

  // Reference model of the counter, the push_credit register and the buffer
  credit_t m_count;
  logic    m_credit_pred;
  data_t   m_q [$];

  // Credits the modelled sender holds and has not spent yet
  int      sender_credits;

  logic [31:0] lcg_state;
  int      errors;
  int      cycles;
  int      cycle_limit;
  int      pulses_seen;
  int      pulses_pred;

  credit_rx_top dut0 (
    .clk               (clk),
    .arst_n            (arst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .deq               (deq),
    .deq_valid         (deq_valid),
    .deq_data          (deq_data),
    .credit_withhold   (credit_withhold),
    .credit_count      (credit_count)
  );

  always #5 clk = ~clk;

  // The watchdog limit is set once the stimulus length is known
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // 32-bit LCG whose bits 23:16 give the beat, since they vary more than the low bits
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("FAILED %s at cycle %0d: expected %0h, actual %0h", name, cycles, expected, actual);
    errors++;
  endtask

  // Lines starting with # are column notes and are skipped
  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    int    f_stall;
    int    f_wh;
    int    f_send;
    int    f_data;
    int    f_deq;
    fd = $fopen("tb_credit_rx_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb_credit_rx_input.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h", f_stall, f_wh, f_send, f_data, f_deq);
      if (n == 5) begin
        st_stall.push_back(f_stall[0]);
        st_withhold.push_back(credit_t'(f_wh));
        st_send.push_back(f_send[0]);
        st_data.push_back(data_t'(f_data));
        st_deq.push_back(f_deq[0]);
      end
    end
    $fclose(fd);
    if (st_stall.size() == 0) begin
      $display("The stimulus file holds no usable lines");
      errors++;
    end
  endtask

  // Called 1 time unit after the edge, when every DUT output is settled
  task automatic check_outputs();
    int total;
    if (push_credit !== m_credit_pred) begin
      report_mismatch("push_credit", m_credit_pred, push_credit);
    end
    if (credit_count !== m_count) begin
      report_mismatch("credit_count", m_count, credit_count);
    end
    if (deq_valid !== (m_q.size() != 0)) begin
      report_mismatch("deq_valid", m_q.size() != 0, deq_valid);
    end
    if (m_q.size() != 0 && deq_data !== m_q[0]) begin
      report_mismatch("deq_data", m_q[0], deq_data);
    end
    // Credits held by the sender, on push_credit, in the buffer and in the DUT counter
    total = sender_credits + int'(push_credit) + m_q.size() + int'(credit_count);
    if (total != RX_DEPTH) begin
      $display("Credit total is %0d at cycle %0d, so a credit was lost or created", total, cycles);
      errors++;
    end
  endtask

  // Drives one stimulus line and steps the model through the coming edge
  task automatic apply_line(input int idx);
    logic    ret;
    logic    take;
    logic    send;
    credit_t avail;
    data_t   beat;
    // The sender sees the pulse in this cycle and may spend it right away
    if (push_credit) begin
      sender_credits++;
      pulses_seen++;
    end
    if (st_data[idx] == 8'hFF) begin
      lcg_state = lcg_next(lcg_state);
      beat = lcg_state[23:16];
    end else begin
      beat = st_data[idx];
    end
    send = st_send[idx] && sender_credits > 0;
    // A dequeue is only legal while the buffer holds something
    ret = st_deq[idx] && m_q.size() != 0;
    push_credit_stall = st_stall[idx];
    credit_withhold   = st_withhold[idx];
    push_valid        = send;
    push_data         = beat;
    deq               = ret;
    if (send) sender_credits--;
    // A returned credit is available for release in the same cycle
    avail = m_count + credit_t'(ret);
    take  = !st_stall[idx] && avail > st_withhold[idx];
    if (take) pulses_pred++;
    m_count       = avail - credit_t'(take);
    m_credit_pred = take;
    if (ret) void'(m_q.pop_front());
    if (send) m_q.push_back(beat);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    clk               = 1'b0;
    arst_n            = 1'b0;
    push_credit_stall = 1'b1;
    push_valid        = 1'b0;
    push_data         = '0;
    deq               = 1'b0;
    credit_withhold   = '0;
    errors            = 0;
    cycles            = 0;
    cycle_limit       = 0;
    pulses_seen       = 0;
    pulses_pred       = 0;
    lcg_state         = 32'd81;
    sender_credits    = 0;
    m_count           = CREDIT_INIT;
    m_credit_pred     = 1'b0;
    load_stimulus();
    cycle_limit = 2 * st_stall.size() + 20;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    for (int i = 0; i < st_stall.size(); i++) begin
      check_outputs();
      apply_line(i);
      @(posedge clk);
      #1;
    end
    // The last grant shows up as a pulse in this final cycle
    check_outputs();
    if (push_credit) pulses_seen++;
    if (pulses_seen != pulses_pred) begin
      report_mismatch("push_credit pulse total", pulses_pred, pulses_seen);
    end
    $display("Run complete after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: credit_rx_assert.sv
module credit_rx_assert (
  input logic                clk,
  input logic                arst_n,
  input logic                push_credit_stall,
  input logic                push_credit,
  input logic                deq,
  input logic                deq_valid,
  input logic                pop_credit,
  input credit_pkg::credit_t credit_withhold,
  input credit_pkg::credit_t credit_count
);

  import credit_pkg::*;

  // ----------------------------------------
  // Link protocol properties
  // ----------------------------------------

  // A stalled cycle grants nothing, so the register stays low after it
  a_stall_blocks_credit: assert property (@(posedge clk) disable iff (!arst_n)
    push_credit_stall |=> !push_credit) else $error("push_credit followed a stall");

  // The consumer only dequeues a non-empty buffer
  a_deq_when_valid: assert property (@(posedge clk) disable iff (!arst_n)
    deq |-> deq_valid) else $error("deq raised while deq_valid is low");

  // Total credit in circulation equals the buffer depth
  a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
    credit_count <= RX_DEPTH) else $error("credit_count above RX_DEPTH");

  // A returned credit goes out again one cycle later unless stall or withhold parks it
  // This covers the case where the count sits exactly at the withhold
  a_return_released: assert property (@(posedge clk) disable iff (!arst_n)
    (pop_credit && !push_credit_stall && credit_count >= credit_withhold) |=> push_credit)
    else $error("returned credit was not released on push_credit");

endmodule

bind credit_rx_top credit_rx_assert u_assert (
  .clk               (clk),
  .arst_n            (arst_n),
  .push_credit_stall (push_credit_stall),
  .push_credit       (push_credit),
  .deq               (deq),
  .deq_valid         (deq_valid),
  .pop_credit        (pop_credit),
  .credit_withhold   (credit_withhold),
  .credit_count      (credit_count)
);

// File: credit_rx_top.sv
module credit_rx_top (
  input  logic                clk,
  input  logic                arst_n,

  // Sender side of the link
  input  logic                push_credit_stall,
  output logic                push_credit,
  input  logic                push_valid,
  input  credit_pkg::data_t   push_data,

  // Local consumer
  input  logic                deq,
  output logic                deq_valid,
  output credit_pkg::data_t   deq_data,

  // Control and status
  input  credit_pkg::credit_t credit_withhold,
  output credit_pkg::credit_t credit_count
);

  import credit_pkg::*;

  // ----------------------------------------
  // Receiver to buffer wiring
  // ----------------------------------------

  // Credit returned by the buffer on every dequeue
  logic  pop_credit;

  // Beat handed from the receiver to the buffer
  logic  pop_valid;
  data_t pop_data;

  // Credit bookkeeping and push_credit generation
  credit_receiver u_receiver (
    .clk               (clk),
    .arst_n            (arst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .pop_credit        (pop_credit),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .credit_withhold   (credit_withhold),
    .credit_count      (credit_count)
  );

  // Dedicated buffer, one slot per credit
  rx_buffer u_buffer (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_valid   (pop_valid),
    .wr_data    (pop_data),
    .deq        (deq),
    .deq_valid  (deq_valid),
    .deq_data   (deq_data),
    .pop_credit (pop_credit)
  );

endmodule

// File: rx_buffer.sv
module rx_buffer (
  input  logic              clk,
  input  logic              arst_n,

  // Write side fed by the credit receiver
  input  logic              wr_valid,
  input  credit_pkg::data_t wr_data,

  // Consumer side
  input  logic              deq,
  output logic              deq_valid,
  output credit_pkg::data_t deq_data,

  // One pulse per retired entry, sent back as a credit
  output logic              pop_credit
);

  import credit_pkg::*;

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------

  // Entry array whose contents are only meaningful between rd_ptr and wr_ptr
  data_t   mem [RX_DEPTH];

  // Next slot to write
  ptr_t    wr_ptr;

  // Oldest stored entry
  ptr_t    rd_ptr;

  // Number of stored entries, from 0 up to RX_DEPTH inclusive
  credit_t occ;

  // Dequeue that actually retires an entry
  logic    deq_accept;

  // Last valid index, used for wrap-around
  localparam ptr_t LAST_IDX = ptr_t'(RX_DEPTH - 1);

  // ----------------------------------------
  // Consumer outputs
  // ----------------------------------------

  // A write shows up here one cycle later, once occ has counted it
  assign deq_valid = occ != '0;

  // Head of the queue is read without a register
  assign deq_data = mem[rd_ptr];

  // A dequeue of an empty buffer is ignored and leaves the pointers alone
  assign deq_accept = deq && deq_valid;

  // The freed slot goes straight back as a credit in the same cycle
  assign pop_credit = deq_accept;

  // ----------------------------------------
  // Write path
  // ----------------------------------------

  // The sender never writes without a credit, so a free slot always exists
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ----------------------------------------
  // Pointer and occupancy update
  // ----------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + ptr_t'(1);
      end
      if (deq_accept) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + ptr_t'(1);
      end
      // Write and dequeue in one cycle leave the count unchanged
      occ <= occ + credit_t'(wr_valid) - credit_t'(deq_accept);
    end
  end

endmodule

// File: credit_receiver.sv
module credit_receiver (
  input  logic                clk,
  input  logic                arst_n,

  // Push side towards the remote sender
  input  logic                push_credit_stall,
  output logic                push_credit,
  input  logic                push_valid,
  input  credit_pkg::data_t   push_data,

  // Pop side towards the receiver buffer
  input  logic                pop_credit,
  output logic                pop_valid,
  output credit_pkg::data_t   pop_data,

  // Credit control and status
  input  credit_pkg::credit_t credit_withhold,
  output credit_pkg::credit_t credit_count
);

  // ----------------------------------------
  // Credit counter
  // ----------------------------------------

  // Request to take one credit from the counter
  logic decr_valid;

  // Counter agrees that a credit may leave
  logic decr_ready;

  // A credit leaves in this cycle and shows up on push_credit in the next
  logic credit_release;

  // Credits returned by the buffer feed the counter as increments
  credit_counter u_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .incr_valid (pop_credit),
    .decr_valid (decr_valid),
    .decr_ready (decr_ready),
    .withhold   (credit_withhold),
    .value      (credit_count)
  );

  // Every cycle without a stall tries to hand out one credit
  assign decr_valid = !push_credit_stall;

  assign credit_release = decr_valid && decr_ready;

  // ----------------------------------------
  // Push credit retiming
  // ----------------------------------------

  // One pulse per released credit, one cycle after the counter grants it
  // The register breaks the path from the counter compare to the link
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push_credit <= 1'b0;
    end else begin
      push_credit <= credit_release;
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  // Beats arrive only under credit, so the buffer always has room
  // Push goes straight to pop in the same cycle with no storage
  assign pop_valid = push_valid;
  assign pop_data  = push_data;

endmodule

// File: credit_counter.sv
module credit_counter (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              incr_valid,
  input  logic              decr_valid,
  output logic              decr_ready,
  input  credit_pkg::credit_t withhold,
  output credit_pkg::credit_t value
);

  import credit_pkg::*;

  // ----------------------------------------
  // Available credit
  // ----------------------------------------

  // Credit that can be handed out this cycle
  // A credit returned in this cycle counts as available straight away
  credit_t avail;

  // High when a decrement is both requested and granted
  logic    decr_taken;

  // Count after this cycle's increment and decrement
  credit_t value_next;

  // The returned credit is added before the withhold comparison
  // A count equal to the withhold can still release when a credit comes back
  // The sum stays well inside CNT_WIDTH bits since the count never passes RX_DEPTH
  assign avail = value + credit_t'(incr_valid);

  // Credits at or below the withhold level stay parked in the counter
  assign decr_ready = avail > withhold;

  assign decr_taken = decr_valid && decr_ready;

  // ----------------------------------------
  // Count update
  // ----------------------------------------

  // Increment and decrement are applied together
  // When both happen the count stays where it is
  assign value_next = avail - credit_t'(decr_taken);

  // Counter register
  // Reset loads the package initial value
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= CREDIT_INIT;
    end else begin
      value <= value_next;
    end
  end

  // There is no clamp at RX_DEPTH
  // The only source of increments is the buffer, which holds at most RX_DEPTH beats,
  // so total credit in circulation never grows past RX_DEPTH
  // Likewise there is no floor at zero, because decr_ready is low whenever avail is zero

endmodule

// File: credit_pkg.sv
package credit_pkg;

  // ----------------------------------------
  // Sizes of the credit link
  // ----------------------------------------

  // Width of one data beat sent by the remote sender
  localparam int DATA_WIDTH = 8;

  // Number of buffer slots, which is also the number of credits in circulation
  localparam int RX_DEPTH = 8;

  // A count must reach RX_DEPTH inclusive, so one extra bit beyond the pointer
  localparam int CNT_WIDTH = $clog2(RX_DEPTH + 1);

  // Index into the receiver buffer
  localparam int PTR_WIDTH = $clog2(RX_DEPTH);

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  typedef logic [DATA_WIDTH-1:0] data_t;

  // Used both for the live credit count and for the withhold threshold
  typedef logic [CNT_WIDTH-1:0] credit_t;

  typedef logic [PTR_WIDTH-1:0] ptr_t;

  // Count loaded while arst_n is low
  // Starting with every slot free lets the receiver release all credits after reset
  localparam credit_t CREDIT_INIT = credit_t'(RX_DEPTH);

endpackage
